//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_video_xy
FILELIST = video_xy.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = TEST RESULT: FAIL
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // half period high, half low
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- bench/tb_video_xy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_xy;
  import vid_geom_pkg::*;
  import vid_sync_pkg::*;

  localparam int MAX_TESTS = 16;
  localparam int FIELDS    = 10;
  localparam int CLK_NS    = 40;

  // expected view of one pixel
  typedef struct packed {
    x_t   x;
    y_t   y;
    logic x_ovf;
    logic y_ovf;
  } exp_pix_t;

  logic       clk;
  logic       rst;
  logic       vsync;
  logic       hsync;
  logic       de;
  win_flags_t win;
  pix_pos_t   pos;
  pos_pulse_t pulse;
  pos_flag_t  flag;

  logic [31:0] stim_mem [0:MAX_TESTS*FIELDS-1];
  exp_pix_t    exp_q [$];
  int          seed = 32'h2522;
  int          errors;
  int          frame_cnt;
  int          lstart_cnt;
  int          lend_cnt;
  int          pix_cnt;
  int          last_x;
  int          last_y;
  int          timeout_ns;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) i_clk (.clk_o(clk));

  video_xy_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .vsync_i (vsync),
    .hsync_i (hsync),
    .de_i    (de),
    .win_o   (win),
    .pos_o   (pos),
    .pulse_o (pulse),
    .flag_o  (flag)
  );

  // ==============================
  // helpers
  // ==============================
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    assert (got === want) else begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic drive(input logic v, input logic h, input logic d);
    @(posedge clk);
    #2;
    vsync = v;
    hsync = h;
    de    = d;
  endtask

  task automatic hold_reset(input int cycles);
    @(posedge clk);
    #2;
    rst   = 1'b1;
    hsync = 1'b0;
    de    = 1'b0;
    repeat (cycles - 1) @(posedge clk);
    @(negedge clk);
    compare_value("win_o", 32'(win), 32'd0);
    compare_value("pos_o", 32'(pos), 32'd0);
    compare_value("pulse_o", 32'(pulse), 32'd0);
    compare_value("flag_o", 32'(flag), 32'd0);
    // pixels still in the pipeline are lost
    exp_q.delete();
    frame_cnt  = 0;
    lstart_cnt = 0;
    lend_cnt   = 0;
    pix_cnt    = 0;
    @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  // one active line followed by padded blanking with an hsync pulse
  task automatic send_line(input int l, input int ppl, input int hblank);
    int       hb;
    exp_pix_t e;
    hb = hblank + ($random(seed) & 3);
    for (int p = 0; p < ppl; p++) begin
      e.x     = x_t'((p < ACTIVE_W_DEF) ? p : ACTIVE_W_DEF - 1);
      e.y     = y_t'((l < ACTIVE_H_DEF) ? l : ACTIVE_H_DEF - 1);
      e.x_ovf = (p >= ACTIVE_W_DEF);
      e.y_ovf = (l >= ACTIVE_H_DEF);
      drive(1'b0, 1'b0, 1'b1);
      exp_q.push_back(e);
    end
    for (int c = 0; c < hb; c++) begin
      drive(1'b0, (c == 1) || (c == 2), 1'b0);
      // the line window still covers the last pixel here
      if (c == 1) begin
        compare_value("win_o.in_line", 32'(win.in_line), 32'd1);
      end
    end
  endtask

  // stop_line below lines leaves the frame open
  task automatic send_frame(input int lines, input int ppl, input int hblank,
                            input bit pre_de, input int stop_line);
    if (pre_de) begin
      // de bursts while vsync is high, outside any frame
      for (int b = 0; b < 15; b++) begin
        drive(1'b1, 1'b0, (b % 5) < 3);
      end
    end else begin
      repeat (4) drive(1'b1, 1'b0, 1'b0);
    end
    repeat (3) drive(1'b0, 1'b0, 1'b0);
    // frame open, no line yet
    compare_value("win_o.in_frame", 32'(win.in_frame), 32'd1);
    compare_value("win_o.in_line", 32'(win.in_line), 32'd0);
    for (int l = 0; l < stop_line; l++) begin
      send_line(l, ppl, hblank);
    end
    if (stop_line == lines) begin
      repeat (2) drive(1'b0, 1'b0, 1'b0);
      repeat (6) drive(1'b1, 1'b0, 1'b0);
      // frame closed by vsync
      compare_value("win_o", 32'(win), 32'd0);
    end
  endtask

  // ==============================
  // scoreboard
  // ==============================
  always @(negedge clk) begin : pixel_monitor
    exp_pix_t e;
    if (!rst) begin
      if (pulse.frame_start) frame_cnt++;
      if (pulse.line_start) lstart_cnt++;
      if (pulse.line_end) lend_cnt++;
      if (pos.valid) begin
        assert (exp_q.size() > 0) else begin
          $display("ERROR: valid pixel at x 0x%0h y 0x%0h when none was sent", pos.x, pos.y);
          errors++;
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          compare_value("pos_o.x", 32'(pos.x), 32'(e.x));
          compare_value("pos_o.y", 32'(pos.y), 32'(e.y));
          compare_value("flag_o.x_overflow", 32'(flag.x_overflow), 32'(e.x_ovf));
          compare_value("flag_o.y_overflow", 32'(flag.y_overflow), 32'(e.y_ovf));
          compare_value("flag_o.x_at_last", 32'(flag.x_at_last),
                        32'(e.x == x_t'(ACTIVE_W_DEF - 1)));
          compare_value("flag_o.y_at_last", 32'(flag.y_at_last),
                        32'(e.y == y_t'(ACTIVE_H_DEF - 1)));
        end
        pix_cnt++;
        last_x = 32'(pos.x);
        last_y = 32'(pos.y);
      end else begin
        compare_value("flag_o.x_at_last", 32'(flag.x_at_last), 32'd0);
        compare_value("flag_o.y_at_last", 32'(flag.y_at_last), 32'd0);
      end
    end
  end

  // watchdog, limit set once the stimulus is known
  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("timeout: the run did not finish within %0d ns", timeout_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ==============================
  // test sequence
  // ==============================
  initial begin
    int    base;
    int    num;
    int    lines;
    int    ppl;
    int    hblank;
    bit    pre_de;
    bit    mid_rst;
    int    cyc;
    int    total;
    int    err_start;
    int    tests_run;
    int    tests_failed;
    string status;

    vsync        = 1'b0;
    hsync        = 1'b0;
    de           = 1'b0;
    rst          = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < MAX_TESTS * FIELDS; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("bench/video_xy_stim.txt", stim_mem);

    // two frame lengths per test plus margin
    total = 200;
    for (int t = 0; t < MAX_TESTS; t++) begin
      base = t * FIELDS;
      if (stim_mem[base] == 0) break;
      cyc = 40 + stim_mem[base+1] * (stim_mem[base+2] + stim_mem[base+3] + 4);
      if (stim_mem[base+5][0]) cyc = cyc * 2;
      total = total + cyc * 2;
    end
    timeout_ns = total * CLK_NS;

    hold_reset(8);

    for (int t = 0; t < MAX_TESTS; t++) begin
      base    = t * FIELDS;
      num     = stim_mem[base];
      if (num == 0) break;
      lines   = stim_mem[base+1];
      ppl     = stim_mem[base+2];
      hblank  = stim_mem[base+3];
      pre_de  = stim_mem[base+4][0];
      mid_rst = stim_mem[base+5][0];

      err_start  = errors;
      frame_cnt  = 0;
      lstart_cnt = 0;
      lend_cnt   = 0;
      pix_cnt    = 0;
      last_x     = 0;
      last_y     = 0;

      if (mid_rst) begin
        send_frame(lines, ppl, hblank, pre_de, lines / 2);
        hold_reset(4);
      end
      send_frame(lines, ppl, hblank, pre_de, lines);

      compare_value("pulse_o.frame_start count", frame_cnt, 1);
      compare_value("pulse_o.line_start count", lstart_cnt, lines);
      compare_value("pulse_o.line_end count", lend_cnt, lines);
      compare_value("pos_o.valid count", pix_cnt, lines * ppl);
      assert (exp_q.size() == 0) else begin
        $display("ERROR: %0d sent pixels never came out", exp_q.size());
        errors++;
      end
      compare_value("last pos_o.x", last_x, stim_mem[base+6]);
      compare_value("last pos_o.y", last_y, stim_mem[base+7]);
      compare_value("final flag_o.x_overflow", 32'(flag.x_overflow), stim_mem[base+8]);
      compare_value("final flag_o.y_overflow", 32'(flag.y_overflow), stim_mem[base+9]);
      exp_q.delete();

      tests_run++;
      status = (errors == err_start) ? "passed" : "failed";
      if (errors != err_start) tests_failed++;
      $display("test %0d %s: %0d lines of %0d pixels, %0d pixels seen",
               num, status, lines, ppl, pix_cnt);
    end

    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_run > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/video_xy_chk.sv
`timescale 1ns/1ps
`default_nettype none

module video_xy_chk (
  input logic                     clk,
  input logic                     rst,
  input vid_sync_pkg::win_flags_t win_i,
  input vid_geom_pkg::pix_pos_t   pos_i,
  input vid_sync_pkg::pos_pulse_t pulse_i
);

  // ==============================
  // frame gating
  // ==============================
  a_valid_in_frame: assert property (@(posedge clk) disable iff (rst)
    pos_i.valid |-> win_i.in_frame)
    else $error("pos_o.valid high while win_o.in_frame is low");

  // ==============================
  // single cycle pulses
  // ==============================
  a_frame_start_one: assert property (@(posedge clk) disable iff (rst)
    pulse_i.frame_start |=> !pulse_i.frame_start)
    else $error("pulse_o.frame_start held for more than one cycle");

  a_line_start_one: assert property (@(posedge clk) disable iff (rst)
    pulse_i.line_start |=> !pulse_i.line_start)
    else $error("pulse_o.line_start held for more than one cycle");

  a_line_end_one: assert property (@(posedge clk) disable iff (rst)
    pulse_i.line_end |=> !pulse_i.line_end)
    else $error("pulse_o.line_end held for more than one cycle");

  // x steps by one, holds, or restarts at 0
  a_x_step: assert property (@(posedge clk) disable iff (rst)
    (pos_i.x != $past(pos_i.x)) |->
      ((pos_i.x == $past(pos_i.x) + 1'b1) || (pos_i.x == '0)))
    else $error("pos_o.x jumped from 0x%0h to 0x%0h", $past(pos_i.x), pos_i.x);

endmodule

bind video_xy_top video_xy_chk i_chk (
  .clk     (clk),
  .rst     (rst),
  .win_i   (win_o),
  .pos_i   (pos_o),
  .pulse_i (pulse_o)
);

`default_nettype wire

//--- bench/video_xy_stim.txt
// columns: test lines pixels hblank pre_de mid_rst
//          last_x last_y x_overflow y_overflow (all hex)

// exact 6 x 32 frame
01 06 20 08 0 0 1f 05 0 0

// long lines, x saturates
02 06 28 08 0 0 1f 05 1 0

// extra lines, y saturates
03 09 20 08 0 0 1f 05 0 1

// de toggling before the frame, short frame
04 03 0a 06 1 0 09 02 0 0

// reset in mid-frame, then a full frame
05 06 20 08 0 1 1f 05 0 0

// both coordinates past the panel
06 09 28 05 0 0 1f 05 1 1

// single pixel frame
07 01 01 04 0 0 00 00 0 0

// gated exact frame with short blanking
08 06 20 04 1 0 1f 05 0 0

// reset with de bursts before each frame
09 06 28 06 1 1 1f 05 1 0

// short frame after overflow
0a 02 05 04 0 0 04 01 0 0

//--- rtl/active_window_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module active_window_tracker (
  input  logic                      clk,
  input  logic                      rst,
  input  vid_sync_pkg::sync_edges_t edges_i,
  output vid_sync_pkg::win_flags_t  win_o
);
  import vid_sync_pkg::*;

  win_state_t state_q;
  win_state_t state_nxt;

  // ==============================
  // next state
  // ==============================
  always_comb begin
    state_nxt = state_q;

    case (state_q)
      WIN_IDLE: begin
        // frame opens on vsync falling edge
        if (edges_i.vs_fall) begin
          state_nxt = edges_i.de_rise ? WIN_LINE : WIN_BLANK;
        end
      end

      WIN_BLANK: begin
        if (edges_i.de_rise) begin
          state_nxt = WIN_LINE;
        end
      end

      WIN_LINE: begin
        // hsync only ends a line that de left open
        if (edges_i.de_fall || edges_i.hs_rise) begin
          state_nxt = WIN_BLANK;
        end
      end

      default: begin
        state_nxt = WIN_IDLE;
      end
    endcase

    // vsync rising edge closes the frame from any state
    if (edges_i.vs_rise) begin
      state_nxt = WIN_IDLE;
    end
  end

  // ==============================
  // state and flag registers
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= WIN_IDLE;
      win_o   <= '0;
    end else begin
      state_q <= state_nxt;

      win_o.in_frame <= (state_nxt != WIN_IDLE);
      win_o.in_line  <= (state_nxt == WIN_LINE);

      // de outside an open line never counts as a pixel
      win_o.pix_valid <= edges_i.de_q & (state_nxt == WIN_LINE);
    end
  end

endmodule

`default_nettype wire

//--- rtl/sync_edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module sync_edge_detect (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      vsync_i,
  input  logic                      hsync_i,
  input  logic                      de_i,
  output vid_sync_pkg::sync_edges_t edges_o
);

  // previous sampled levels of vsync and hsync
  logic vs_d;
  logic hs_d;

  // ==============================
  // edge pulses
  // ==============================
  // de history lives in edges_o.de_q, which is the
  // delayed de level handed on with the pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      vs_d    <= 1'b0;
      hs_d    <= 1'b0;
      edges_o <= '0;
    end else begin
      edges_o.vs_rise <=  vsync_i & ~vs_d;
      edges_o.vs_fall <= ~vsync_i &  vs_d;

      edges_o.hs_rise <=  hsync_i & ~hs_d;
      edges_o.hs_fall <= ~hsync_i &  hs_d;

      edges_o.de_rise <=  de_i & ~edges_o.de_q;
      edges_o.de_fall <= ~de_i &  edges_o.de_q;

      // level delayed to match the pulses
      edges_o.de_q <= de_i;

      vs_d <= vsync_i;
      hs_d <= hsync_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vid_geom_pkg.sv
`default_nettype none

package vid_geom_pkg;

  // ==============================
  // coordinate widths
  // ==============================
  localparam int X_W = 11;
  localparam int Y_W = 10;

  // ==============================
  // default panel geometry
  // ==============================
  localparam int ACTIVE_W_DEF = 32;
  localparam int ACTIVE_H_DEF = 6;

  // column and row numbers
  typedef logic [X_W-1:0] x_t;
  typedef logic [Y_W-1:0] y_t;

  // coordinate of one pixel, valid marks a real pixel
  typedef struct packed {
    x_t   x;
    y_t   y;
    logic valid;
  } pix_pos_t;

endpackage

`default_nettype wire

//--- rtl/vid_sync_pkg.sv
`default_nettype none

package vid_sync_pkg;

  // ==============================
  // sync edge events
  // ==============================
  // one-cycle pulses, de_q lines up with them
  typedef struct packed {
    logic vs_rise;
    logic vs_fall;
    logic hs_rise;
    logic hs_fall;
    logic de_rise;
    logic de_fall;
    logic de_q;
  } sync_edges_t;

  // ==============================
  // window tracking
  // ==============================
  typedef enum logic [1:0] {
    WIN_IDLE  = 2'd0,
    WIN_BLANK = 2'd1,
    WIN_LINE  = 2'd2
  } win_state_t;

  typedef struct packed {
    logic in_frame;
    logic in_line;
    logic pix_valid;
  } win_flags_t;

  // position markers from the counter
  typedef struct packed {
    logic frame_start;
    logic line_start;
    logic line_end;
  } pos_pulse_t;

  typedef struct packed {
    logic x_at_last;
    logic y_at_last;
    logic x_overflow;
    logic y_overflow;
  } pos_flag_t;

endpackage

`default_nettype wire

//--- rtl/video_xy_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_xy_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     vsync_i,
  input  logic                     hsync_i,
  input  logic                     de_i,
  output vid_sync_pkg::win_flags_t win_o,
  output vid_geom_pkg::pix_pos_t   pos_o,
  output vid_sync_pkg::pos_pulse_t pulse_o,
  output vid_sync_pkg::pos_flag_t  flag_o
);
  import vid_sync_pkg::*;

  // edge pulses shared by tracker and counter
  sync_edges_t edges;

  // ==============================
  // sync edges
  // ==============================
  sync_edge_detect u_edge (
    .clk     (clk),
    .rst     (rst),
    .vsync_i (vsync_i),
    .hsync_i (hsync_i),
    .de_i    (de_i),
    .edges_o (edges)
  );

  // ==============================
  // frame and line window
  // ==============================
  active_window_tracker u_awt (
    .clk     (clk),
    .rst     (rst),
    .edges_i (edges),
    .win_o   (win_o)
  );

  // ==============================
  // coordinates
  // ==============================
  xy_counter u_xy (
    .clk     (clk),
    .rst     (rst),
    .edges_i (edges),
    .win_i   (win_o),
    .pos_o   (pos_o),
    .pulse_o (pulse_o),
    .flag_o  (flag_o)
  );

endmodule

`default_nettype wire

//--- rtl/xy_counter.sv
`timescale 1ns/1ps
`default_nettype none

module xy_counter #(
  parameter int ACTIVE_W = vid_geom_pkg::ACTIVE_W_DEF,
  parameter int ACTIVE_H = vid_geom_pkg::ACTIVE_H_DEF
) (
  input  logic                      clk,
  input  logic                      rst,
  input  vid_sync_pkg::sync_edges_t edges_i,
  input  vid_sync_pkg::win_flags_t  win_i,
  output vid_geom_pkg::pix_pos_t    pos_o,
  output vid_sync_pkg::pos_pulse_t  pulse_o,
  output vid_sync_pkg::pos_flag_t   flag_o
);
  import vid_geom_pkg::*;
  import vid_sync_pkg::*;

  localparam x_t LAST_X = x_t'(ACTIVE_W - 1);
  localparam y_t LAST_Y = y_t'(ACTIVE_H - 1);

  // pix_valid of the previous cycle
  logic pv_q;
  // frame opened, first line not seen yet
  logic frame_pend_q;
  // a line on the last row has completed
  logic y_full_q;

  logic line_start;
  logic line_end;
  logic frame_start;
  logic x_sat;
  x_t   x_nxt;
  y_t   y_nxt;

  // ==============================
  // transitions of pix_valid
  // ==============================
  assign line_start  =  win_i.pix_valid & ~pv_q;
  assign line_end    = ~win_i.pix_valid &  pv_q;
  assign frame_start =  line_start & frame_pend_q;
  assign x_sat       = (pos_o.x == LAST_X);

  // column, restarts on each line and holds at the last column
  always_comb begin
    x_nxt = pos_o.x;
    if (line_start) begin
      x_nxt = '0;
    end else if (win_i.pix_valid && !x_sat) begin
      x_nxt = pos_o.x + 1'b1;
    end
  end

  // row, restarts on each frame and holds at the last row
  always_comb begin
    y_nxt = pos_o.y;
    if (frame_start) begin
      y_nxt = '0;
    end else if (line_end && (pos_o.y != LAST_Y)) begin
      y_nxt = pos_o.y + 1'b1;
    end
  end

  // ==============================
  // registers
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      pv_q         <= 1'b0;
      frame_pend_q <= 1'b0;
      y_full_q     <= 1'b0;
      pos_o        <= '0;
      pulse_o      <= '0;
      flag_o       <= '0;
    end else begin
      pv_q <= win_i.pix_valid;

      // arm on frame open, disarm on close or first line
      if (edges_i.vs_fall) begin
        frame_pend_q <= 1'b1;
      end else if (edges_i.vs_rise || frame_start) begin
        frame_pend_q <= 1'b0;
      end

      pos_o.x     <= x_nxt;
      pos_o.y     <= y_nxt;
      pos_o.valid <= win_i.pix_valid;

      pulse_o.frame_start <= frame_start;
      pulse_o.line_start  <= line_start;
      pulse_o.line_end    <= line_end;

      flag_o.x_at_last <= win_i.pix_valid & (x_nxt == LAST_X);
      flag_o.y_at_last <= win_i.pix_valid & (y_nxt == LAST_Y);

      // pixel past the last column
      if (line_start) begin
        flag_o.x_overflow <= 1'b0;
      end else if (win_i.pix_valid && x_sat) begin
        flag_o.x_overflow <= 1'b1;
      end

      // line past the last row
      if (frame_start) begin
        y_full_q          <= 1'b0;
        flag_o.y_overflow <= 1'b0;
      end else begin
        if (line_end && (pos_o.y == LAST_Y)) begin
          y_full_q <= 1'b1;
        end
        if (line_start && y_full_q) begin
          flag_o.y_overflow <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- video_xy.f
rtl/vid_geom_pkg.sv
rtl/vid_sync_pkg.sv
rtl/sync_edge_detect.sv
rtl/active_window_tracker.sv
rtl/xy_counter.sv
rtl/video_xy_top.sv
bench/tb_clk_gen.sv
bench/video_xy_chk.sv
bench/tb_video_xy.sv
